// ==== common/busPkg.sv ====
package busPkg;

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////

    // Boot ROM window, 0x00F80000 to 0x00FFFFFF
    localparam logic [31:0] ROM_BASE = 32'h00F8_0000;
    localparam logic [31:0] ROM_MASK = 32'hFFF8_0000;

    // Region byte in A23..A16 for both CIAs
    localparam logic [7:0] CIA_REGION = 8'hBF;

    // Transfer type of an interrupt acknowledge
    localparam logic [1:0] TT_ACK = 2'b11;

    ////////////////////////////////////////////////////////////
    // Timing
    ////////////////////////////////////////////////////////////

    // CLK40 cycles per CIA clock period
    localparam int CIA_DIV = 40;
    // Half period, high and low phases are equal
    localparam int CIA_HALF = CIA_DIV / 2;
    localparam int CIA_CNT_W = $clog2(CIA_HALF);

    // Clocks from ts to acknowledge for ROM
    localparam int ROM_WAIT = 3;
    localparam int ROM_CNT_W = $clog2(ROM_WAIT);

    ////////////////////////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////////////////////////

    // CIA reading of the address, chip selects are active low
    typedef struct packed {
        logic [7:0] unused;
        logic [7:0] region;
        logic [1:0] upperOffs;
        logic       csBn;
        logic       csAn;
        logic [3:0] regSel;
        logic [7:0] low;
    } ciaView_t;

    // One address word, read flat for ROM and by field for CIA
    typedef union packed {
        logic [31:0] flat;
        ciaView_t    ciaView;
    } busAddr_u;

    // Processor request as seen on the bus
    typedef struct packed {
        logic       ts;
        busAddr_u   addr;
        logic [1:0] tt;
    } busReq_t;

    // Decoded cycle, held until the acknowledge
    typedef struct packed {
        logic       pending;
        logic       rom;
        logic       cia;
        logic       autoVec;
        logic [1:0] ciaCs;
    } cycleSpace_t;

    // Termination outputs
    typedef struct packed {
        logic ta;
        logic taDrive;
        logic tci;
    } termOut_t;

endpackage

// ==== hw/addressDecode.sv ====
module addressDecode import busPkg::*; (
    input  logic        CLK40,
    input  logic        nRESET,
    input  busReq_t     req,
    input  logic        ta,
    output cycleSpace_t space,
    output logic        romSelect,
    output logic [1:0]  ciaCs
);

    ////////////////////////////////////////////////////////////
    // Decode of the address on the bus
    ////////////////////////////////////////////////////////////

    logic        romHit;
    logic        ciaHit;
    cycleSpace_t decoded;

    always_comb begin
        // Flat view against the ROM window
        romHit = (req.addr.flat & ROM_MASK) == ROM_BASE;
        // CIA region with at least one chip pulled low
        ciaHit = (req.addr.ciaView.region == CIA_REGION) &&
                 !(req.addr.ciaView.csAn && req.addr.ciaView.csBn);

        decoded = '0;
        decoded.pending = 1'b1;
        // Interrupt acknowledge wins over any address match
        if (req.tt == TT_ACK) begin
            decoded.autoVec = 1'b1;
        end else if (romHit) begin
            decoded.rom = 1'b1;
        end else if (ciaHit) begin
            decoded.cia = 1'b1;
            // Bit 0 is CIA-A on A12, bit 1 is CIA-B on A13
            decoded.ciaCs = {!req.addr.ciaView.csBn, !req.addr.ciaView.csAn};
        end
        // No match leaves pending set with no space flag
    end

    ////////////////////////////////////////////////////////////
    // Cycle register
    ////////////////////////////////////////////////////////////

    // Loaded on ts, cleared on the edge that samples ta
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            space <= '0;
        end else if (ta) begin
            space <= '0;
        end else if (req.ts) begin
            space <= decoded;
        end
    end

    // Selects follow the held decode
    assign romSelect = space.rom;
    assign ciaCs = space.ciaCs;

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Master must wait for the acknowledge before the next start
    assert property (@(posedge CLK40) disable iff (!nRESET)
        req.ts |-> !space.pending)
        else $error("ts during pending cycle");

    // At most one space per cycle, unmapped has none
    assert property (@(posedge CLK40) disable iff (!nRESET)
        space.pending |-> $onehot0({space.rom, space.cia, space.autoVec}))
        else $error("space flags not one-hot");

endmodule

// ==== hw/ciaClockGen.sv ====
module ciaClockGen import busPkg::*; (
    input  logic CLK40,
    input  logic nRESET,
    output logic ciaClk
);

    ////////////////////////////////////////////////////////////
    // CIA clock divider
    ////////////////////////////////////////////////////////////

    // Counts CLK40 cycles within one half period
    logic [CIA_CNT_W-1:0] halfCount;
    logic                 halfDone;

    assign halfDone = halfCount == CIA_CNT_W'(CIA_HALF - 1);

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            halfCount <= '0;
            // Low phase comes first after reset
            ciaClk <= 1'b0;
        end else if (halfDone) begin
            halfCount <= '0;
            ciaClk <= !ciaClk;
        end else begin
            halfCount <= halfCount + 1'b1;
        end
    end

endmodule

// ==== transferAck/ciaSync.sv ====
module ciaSync (
    input  logic CLK40,
    input  logic nRESET,
    input  logic ciaClk,
    input  logic ciaCycle,
    output logic ciaTa
);

    ////////////////////////////////////////////////////////////
    // CIA clock synchronizer and acknowledge
    ////////////////////////////////////////////////////////////

    // Two samples of the CIA clock, newest in bit 0
    logic [1:0] clkHist;
    // Set once the high phase was seen during a CIA cycle
    logic       armed;

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            clkHist <= 2'b00;
            armed <= 1'b0;
            ciaTa <= 1'b0;
        end else begin
            clkHist <= {clkHist[0], ciaClk};

            if (clkHist == 2'b11 && ciaCycle) begin
                armed <= 1'b1;
                ciaTa <= 1'b0;
            end else if (clkHist == 2'b00 && armed) begin
                // Falling edge passed, CIA has latched its data
                ciaTa <= 1'b1;
                armed <= 1'b0;
            end else begin
                ciaTa <= 1'b0;
            end
        end
    end

    // Single clock pulse only
    assert property (@(posedge CLK40) disable iff (!nRESET)
        ciaTa |=> !ciaTa)
        else $error("ciaTa held for two clocks");

endmodule

// ==== transferAck/transferAck.sv ====
module transferAck import busPkg::*; (
    input  logic        CLK40,
    input  logic        nRESET,
    input  busReq_t     req,
    input  cycleSpace_t space,
    input  logic        ciaClk,
    output termOut_t    term
);

    logic romTa;
    logic scTa;
    logic ciaTa;
    logic driveHold;
    logic tsLast;
    logic mappedPending;

    logic [ROM_CNT_W-1:0] romCount;

    ////////////////////////////////////////////////////////////
    // ROM acknowledge delay
    ////////////////////////////////////////////////////////////

    // Space flags are valid one clock after ts
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            tsLast <= 1'b0;
        end else begin
            tsLast <= req.ts;
        end
    end

    // Holds ta off to meet the ROM setup time
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            romCount <= '0;
            romTa <= 1'b0;
        end else if (romCount == '0) begin
            romTa <= 1'b0;
            // Start on the first clock of a ROM cycle
            if (tsLast && space.rom) begin
                romCount <= ROM_CNT_W'(1);
            end
        end else if (romCount == ROM_CNT_W'(ROM_WAIT - 2)) begin
            romTa <= 1'b1;
            romCount <= '0;
        end else begin
            romCount <= romCount + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Short cycle acknowledge
    ////////////////////////////////////////////////////////////

    // Autovector ends in the clock right after ts
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            scTa <= 1'b0;
        end else begin
            scTa <= req.ts && (req.tt == TT_ACK);
        end
    end

    ////////////////////////////////////////////////////////////
    // CIA acknowledge
    ////////////////////////////////////////////////////////////

    ciaSync i_ciaSync (
        .CLK40    (CLK40),
        .nRESET   (nRESET),
        .ciaClk   (ciaClk),
        .ciaCycle (space.pending && space.cia),
        .ciaTa    (ciaTa)
    );

    ////////////////////////////////////////////////////////////
    // Merge and line drive
    ////////////////////////////////////////////////////////////

    // Unmapped cycles never drive the line
    assign mappedPending = space.pending && (space.rom || space.cia || space.autoVec);

    // Drives ta high one clock after the cycle ends
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            driveHold <= 1'b0;
        end else begin
            driveHold <= term.ta;
        end
    end

    assign term.ta = romTa || scTa || ciaTa;
    assign term.taDrive = mappedPending || driveHold;
    // CIA registers must not be cached
    assign term.tci = term.ta && space.cia;

    // Acknowledge only inside a decoded cycle
    assert property (@(posedge CLK40) disable iff (!nRESET)
        term.ta |-> space.pending)
        else $error("ta outside a pending cycle");

endmodule

// ==== hw/busTermTop.sv ====
module busTermTop import busPkg::*; (
    input  logic       CLK40,
    input  logic       nRESET,
    input  busReq_t    req,
    output termOut_t   term,
    output logic       romSelect,
    output logic [1:0] ciaCs,
    output logic       ciaClk
);

    ////////////////////////////////////////////////////////////
    // Bus termination subsystem
    ////////////////////////////////////////////////////////////

    // Held decode of the current cycle
    cycleSpace_t space;

    // Decoder, cleared by the acknowledge it receives back
    addressDecode i_addressDecode (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .req       (req),
        .ta        (term.ta),
        .space     (space),
        .romSelect (romSelect),
        .ciaCs     (ciaCs)
    );

    // Slow CIA clock
    ciaClockGen i_ciaClockGen (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .ciaClk (ciaClk)
    );

    // Acknowledge, cache inhibit and line drive
    transferAck i_transferAck (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .req    (req),
        .space  (space),
        .ciaClk (ciaClk),
        .term   (term)
    );

endmodule

// ==== test/busTermTb.sv ====
module busTermTb import busPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////////////////////////////////////////////
    // Run limits and model constants
    ////////////////////////////////////////////////////////////

    localparam int NUM_CYCLES = 200;
    localparam int CIA_MAX_WAIT = 2 * CIA_DIV + 4;
    localparam int UNMAPPED_WAIT = 100;
    localparam int CYCLE_LIMIT = NUM_CYCLES * CIA_MAX_WAIT + 2000;

    // Boot ROM window from the address map
    localparam logic [31:0] ROM_LO = 32'h00F8_0000;
    localparam logic [31:0] ROM_HI = 32'h00FF_FFFF;

    // Space classes of the model
    localparam int SP_ROM = 0;
    localparam int SP_CIAA = 1;
    localparam int SP_CIAB = 2;
    localparam int SP_CIAAB = 3;
    localparam int SP_AUTO = 4;
    localparam int SP_NONE = 5;

    logic       CLK40;
    logic       nRESET;
    busReq_t    req;
    termOut_t   term;
    logic       romSelect;
    logic [1:0] ciaCs;
    logic       ciaClk;

    int errorCount = 0;
    int testCount = 0;
    int failCount = 0;
    int cycleCount = 0;
    // CLK40 edges since reset release give the CIA clock phase
    int edgeCount = 0;

    busTermTop i_dut (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .req       (req),
        .term      (term),
        .romSelect (romSelect),
        .ciaCs     (ciaCs),
        .ciaClk    (ciaClk)
    );

    // 8 ns period
    always #4 CLK40 = !CLK40;

    always @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            edgeCount <= 0;
        end else begin
            edgeCount <= edgeCount + 1;
        end
    end

    // Guard against a hung run
    always @(posedge CLK40) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d clocks without finishing", cycleCount);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Interrupt acknowledge first, then ROM, then CIA with a select low
    function automatic int decodeSpace(logic [31:0] addr, logic [1:0] tt);
        if (tt == TT_ACK) return SP_AUTO;
        if (addr >= ROM_LO && addr <= ROM_HI) return SP_ROM;
        if (addr[23:16] != 8'hBF) return SP_NONE;
        // A13 selects CIA-B, A12 selects CIA-A, both active low
        case (addr[13:12])
            2'b10: return SP_CIAA;
            2'b01: return SP_CIAB;
            2'b00: return SP_CIAAB;
            default: return SP_NONE;
        endcase
    endfunction

    function automatic logic [1:0] expectedCs(int sp);
        case (sp)
            SP_CIAA: return 2'b01;
            SP_CIAB: return 2'b10;
            SP_CIAAB: return 2'b11;
            default: return 2'b00;
        endcase
    endfunction

    function automatic string spaceName(int sp);
        case (sp)
            SP_ROM: return "ROM";
            SP_CIAA: return "CIA-A";
            SP_CIAB: return "CIA-B";
            SP_CIAAB: return "CIA-AB";
            SP_AUTO: return "autovector";
            default: return "unmapped";
        endcase
    endfunction

    // Random address inside the chosen space
    function automatic logic [31:0] makeAddress(int sp);
        logic [31:0] addr;
        addr = $urandom;
        case (sp)
            SP_ROM: addr = ROM_LO | (addr & 32'h0007_FFFF);
            SP_CIAA: addr = {addr[31:24], 8'hBF, addr[15:14], 2'b10, addr[11:0]};
            SP_CIAB: addr = {addr[31:24], 8'hBF, addr[15:14], 2'b01, addr[11:0]};
            SP_CIAAB: addr = {addr[31:24], 8'hBF, addr[15:14], 2'b00, addr[11:0]};
            SP_AUTO: begin
                // ROM and CIA addresses show that the transfer type wins
                case (addr[1:0])
                    2'b00: addr = ROM_LO | (addr & 32'h0007_FFFF);
                    2'b01: addr = {addr[31:24], 8'hBF, addr[15:14], 2'b00, addr[11:0]};
                    default: ;
                endcase
            end
            SP_NONE: begin
                if (addr[0]) begin
                    // CIA region with no chip selected
                    addr = {addr[31:24], 8'hBF, addr[15:14], 2'b11, addr[11:0]};
                end else begin
                    if (addr[23:16] == 8'hBF) addr[16] = 1'b0;
                    if (addr >= ROM_LO && addr <= ROM_HI) addr[23] = 1'b0;
                end
            end
            default: ;
        endcase
        return addr;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic compareValue(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual == expected) else begin
            $display("Fail %s expected %h got %h at %0t", name, expected, actual, $time);
            errorCount++;
        end
    endtask

    // CIA clock starts low and toggles every half period
    task automatic checkClockPhase();
        compareValue("ciaClk", (edgeCount / CIA_HALF) % 2, ciaClk);
    endtask

    task automatic checkIdle();
        compareValue("ta", 0, term.ta);
        compareValue("taDrive", 0, term.taDrive);
        compareValue("tci", 0, term.tci);
        compareValue("romSelect", 0, romSelect);
        compareValue("ciaCs", 0, ciaCs);
        checkClockPhase();
    endtask

    task automatic resetDut();
        int i;
        nRESET = 1'b0;
        req = '0;
        for (i = 0; i < 4; i++) begin
            @(negedge CLK40);
            checkIdle();
            compareValue("ciaClk", 0, ciaClk);
        end
        nRESET = 1'b1;
    endtask

    task automatic idleClocks(int count);
        int i;
        for (i = 0; i < count; i++) begin
            @(negedge CLK40);
            checkIdle();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus master
    ////////////////////////////////////////////////////////////

    task automatic runBusCycle(int index);
        int          sp;
        int          expSp;
        int          k;
        int          latency;
        int          errorsBefore;
        logic [31:0] addr;
        logic [1:0]  tt;
        logic        isCia;
        logic        seenTa;
        errorsBefore = errorCount;
        latency = 0;
        sp = int'($urandom % 6);
        addr = makeAddress(sp);
        tt = (sp == SP_AUTO) ? TT_ACK : 2'($urandom % 3);
        expSp = decodeSpace(addr, tt);
        isCia = expSp == SP_CIAA || expSp == SP_CIAB || expSp == SP_CIAAB;

        // One clock of ts starts the cycle
        req.ts = 1'b1;
        req.addr.flat = addr;
        req.tt = tt;
        @(negedge CLK40);
        // Bus lines change once ts is gone and the decode must hold
        req.ts = 1'b0;
        req.addr.flat = $urandom;
        req.tt = 2'($urandom);

        if (expSp == SP_NONE) begin
            for (k = 1; k <= UNMAPPED_WAIT; k++) begin
                checkIdle();
                @(negedge CLK40);
            end
            // Only a reset clears the stuck pending flag
            resetDut();
        end else begin
            seenTa = 1'b0;
            k = 1;
            while (!seenTa && k <= CIA_MAX_WAIT) begin
                compareValue("taDrive", 1, term.taDrive);
                compareValue("romSelect", expSp == SP_ROM, romSelect);
                compareValue("ciaCs", expectedCs(expSp), ciaCs);
                compareValue("tci", term.ta && isCia, term.tci);
                checkClockPhase();
                if (expSp == SP_ROM) compareValue("ta", k == ROM_WAIT, term.ta);
                if (expSp == SP_AUTO) compareValue("ta", k == 1, term.ta);
                if (term.ta) begin
                    seenTa = 1'b1;
                    latency = k;
                    // CIA ack lands in the low half of its clock
                    if (isCia) compareValue("ciaClk", 0, ciaClk);
                end
                @(negedge CLK40);
                k++;
            end
            assert (seenTa) else begin
                $display("No ta within %0d clocks of ts in %s cycle", CIA_MAX_WAIT,
                         spaceName(expSp));
                errorCount++;
            end
            if (seenTa) begin
                // Drive-hold clock pulls the line high
                compareValue("ta", 0, term.ta);
                compareValue("taDrive", 1, term.taDrive);
                compareValue("tci", 0, term.tci);
                compareValue("romSelect", 0, romSelect);
                compareValue("ciaCs", 0, ciaCs);
                checkClockPhase();
            end else begin
                resetDut();
            end
        end

        testCount++;
        if (errorCount != errorsBefore) failCount++;
        $display("Cycle %0d %s addr %h tt %0d latency %0d: %s", index, spaceName(expSp),
                 addr, tt, latency, (errorCount == errorsBefore) ? "ok" : "errors");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int i;
        int errorsBefore;
        CLK40 = 1'b0;
        nRESET = 1'b0;
        req = '0;
        void'($urandom(46));

        // Reset values before any ts
        errorsBefore = errorCount;
        resetDut();
        idleClocks(3);
        testCount++;
        if (errorCount != errorsBefore) failCount++;
        $display("Reset values: %s", (errorCount == errorsBefore) ? "ok" : "errors");

        for (i = 0; i < NUM_CYCLES; i++) begin
            runBusCycle(i);
            idleClocks(int'($urandom % 4));
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 testCount, testCount - failCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
common/busPkg.sv
hw/addressDecode.sv
hw/ciaClockGen.sv
transferAck/ciaSync.sv
transferAck/transferAck.sv
hw/busTermTop.sv
test/busTermTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the bus termination testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=busTermSim
LOG_FILE=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        -f project.f --top-module busTermTb \
        -Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
    echo "Verilator compile step did not succeed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "all tests passed" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
